//--- logic/video_pkg.sv
package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Pixel and coordinate widths
    // ~~~~~~~~~~~~~~~~~~~~

    typedef logic [15:0] pixel_t;   // RGB565, red in the top bits
    typedef logic [11:0] coord_t;   // Covers line and frame totals up to 4095

    // ~~~~~~~~~~~~~~~~~~~~
    // Port bundles
    // ~~~~~~~~~~~~~~~~~~~~

    // Camera side, one pixel per clock while href is high
    typedef struct packed {
        logic   href;
        pixel_t data;
    } cam_stream_t;

    // Display control outputs, all active high
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic data_en;
    } video_sync_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Lock sequencing
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        LOCK_COUNT = 2'd0,   // Counting camera line ends
        LOCK_WAIT  = 2'd1,   // Capturing, display not yet started
        LOCK_RUN   = 2'd2    // Display timing free-running
    } lock_state_t;

endpackage : video_pkg

//--- logic/display_lock.sv
`timescale 1ns/100ps

module display_lock #(
    parameter int LOCK_LINES  = 480,
    parameter int START_DELAY = 36164
) (
    input  logic clk,
    input  logic rstn,
    input  logic href,
    output logic capture_en,
    output logic timing_run
);

    import video_pkg::*;

    // One counter serves both phases, so it must hold the larger bound
    localparam int CNT_MAX = (START_DELAY > LOCK_LINES) ? START_DELAY : LOCK_LINES;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    localparam logic [CNT_W-1:0] LINES_LAST = CNT_W'(LOCK_LINES - 1);
    localparam logic [CNT_W-1:0] DELAY_LAST = CNT_W'(START_DELAY - 1);

    lock_state_t      state;
    logic             href_d;
    logic             href_fall;
    logic [CNT_W-1:0] cnt;

    assign href_fall = href_d & ~href;   // First low sample after a line

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            href_d <= 1'b0;
            cnt    <= '0;
            state  <= LOCK_COUNT;
        end else begin
            href_d <= href;
            case (state)
                LOCK_COUNT: begin
                    if (href_fall) begin
                        if (cnt == LINES_LAST) begin
                            cnt   <= '0;
                            state <= LOCK_WAIT;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                LOCK_WAIT: begin
                    // Run starts START_DELAY cycles after entering this state
                    if (cnt == DELAY_LAST) begin
                        cnt   <= '0;
                        state <= LOCK_RUN;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LOCK_RUN: begin
                    state <= LOCK_RUN;   // No re-lock, stays here until reset
                end
                default: begin
                    cnt   <= '0;
                    state <= LOCK_COUNT;
                end
            endcase
        end
    end

    // Both outputs decode the state register directly
    assign capture_en = (state == LOCK_WAIT) || (state == LOCK_RUN);
    assign timing_run = (state == LOCK_RUN);

endmodule : display_lock

//--- logic/video_timing.sv
`timescale 1ns/100ps

module video_timing #(
    parameter int H_ACT  = 640,
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_ACT  = 480,
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 run,
    output logic                 read_en,
    output video_pkg::video_sync_t sync,
    output video_pkg::coord_t    x,
    output video_pkg::coord_t    y
);

    import video_pkg::*;

    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;

    // ~~~~~~~~~~~~~~~~~~~~
    // Region bounds in counter width
    // ~~~~~~~~~~~~~~~~~~~~

    localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT_END  = coord_t'(H_ACT);
    localparam coord_t V_ACT_END  = coord_t'(V_ACT);
    localparam coord_t HS_START   = coord_t'(H_ACT + H_FP);
    localparam coord_t HS_END     = coord_t'(H_ACT + H_FP + H_SYNC);
    localparam coord_t VS_START   = coord_t'(V_ACT + V_FP);
    localparam coord_t VS_END     = coord_t'(V_ACT + V_FP + V_SYNC);

    coord_t h;
    coord_t v;
    logic   h_sync_region;
    logic   v_sync_region;

    // ~~~~~~~~~~~~~~~~~~~~
    // Counters
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            h <= '0;
            v <= '0;
        end else if (run) begin
            if (h == H_LAST) begin
                h <= '0;
                if (v == V_LAST) begin
                    v <= '0;
                end else begin
                    v <= v + 1'b1;
                end
            end else begin
                h <= h + 1'b1;
            end
        end
    end

    // Read request goes out with the counters, the FIFO answers a cycle later
    assign read_en = run && (h < H_ACT_END) && (v < V_ACT_END);

    assign h_sync_region = (h >= HS_START) && (h < HS_END);
    assign v_sync_region = (v >= VS_START) && (v < VS_END);   // Whole lines

    // ~~~~~~~~~~~~~~~~~~~~
    // Output stage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sync <= '0;
            x    <= '0;
            y    <= '0;
        end else begin
            sync.data_en <= read_en;
            sync.hsync   <= run && h_sync_region;
            sync.vsync   <= run && v_sync_region;
            x            <= h;
            y            <= v;
        end
    end

endmodule : video_timing

//--- logic/line_fifo.sv
`timescale 1ns/100ps

module line_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic              clk,
    input  logic              rstn,
    input  logic              write_en,
    input  logic              href,
    input  video_pkg::pixel_t pixel_in,
    input  logic              read_en,
    output video_pkg::pixel_t pixel_out,
    output logic              overflow,
    output logic              underflow
);

    import video_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

    pixel_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_req;
    logic             wr_ok;
    logic             rd_ok;

    assign wr_req = write_en && href;
    assign wr_ok  = wr_req && (count != CNT_FULL);   // Full FIFO drops the pixel
    assign rd_ok  = read_en && (count != '0);        // No fall-through when empty

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            overflow  <= 1'b0;
            underflow <= 1'b0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_ok) - CNT_W'(rd_ok);
            if (wr_req && !wr_ok) begin
                overflow <= 1'b1;
            end
            if (read_en && !rd_ok) begin
                underflow <= 1'b1;
            end
        end
    end

    // An empty read leaves the previous pixel on the output
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= pixel_in;
        end
        if (rd_ok) begin
            pixel_out <= mem[rd_ptr];
        end
    end

endmodule : line_fifo

//--- logic/video_top.sv
`timescale 1ns/100ps

module video_top #(
    parameter int H_ACT      = 640,
    parameter int H_FP       = 16,
    parameter int H_SYNC     = 96,
    parameter int H_BP       = 48,
    parameter int V_ACT      = 480,
    parameter int V_FP       = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BP       = 33,
    parameter int LOCK_LINES = 480,
    parameter int LOCK_LEAD  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  video_pkg::cam_stream_t cam,
    output video_pkg::video_sync_t sync,
    output video_pkg::coord_t      x,
    output video_pkg::coord_t      y,
    output video_pkg::pixel_t      pix,
    output logic                   overflow,
    output logic                   underflow
);

    localparam int H_TOTAL = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SYNC + V_BP;

    // Camera blanking from the last active line to the next frame, plus read lag
    localparam int START_DELAY = (H_TOTAL - H_ACT) + (V_TOTAL - V_ACT) * H_TOTAL + LOCK_LEAD;

    logic capture_en;
    logic timing_run;
    logic read_en;

    display_lock #(
        .LOCK_LINES (LOCK_LINES),
        .START_DELAY(START_DELAY)
    ) u_lock (
        .clk       (clk),
        .rstn      (rstn),
        .href      (cam.href),
        .capture_en(capture_en),
        .timing_run(timing_run)
    );

    video_timing #(
        .H_ACT (H_ACT),
        .H_FP  (H_FP),
        .H_SYNC(H_SYNC),
        .H_BP  (H_BP),
        .V_ACT (V_ACT),
        .V_FP  (V_FP),
        .V_SYNC(V_SYNC),
        .V_BP  (V_BP)
    ) u_timing (
        .clk    (clk),
        .rstn   (rstn),
        .run    (timing_run),
        .read_en(read_en),
        .sync   (sync),
        .x      (x),
        .y      (y)
    );

    line_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .rstn     (rstn),
        .write_en (capture_en),
        .href     (cam.href),
        .pixel_in (cam.data),
        .read_en  (read_en),
        .pixel_out(pix),
        .overflow (overflow),
        .underflow(underflow)
    );

endmodule : video_top

//--- tests/video_assert.sv
`timescale 1ns/100ps

module video_assert (
    input logic                   clk,
    input logic                   rstn,
    input logic                   timing_run,
    input video_pkg::video_sync_t sync,
    input logic                   overflow,
    input logic                   underflow
);

    // ~~~~~~~~~~~~~~~~~~~~
    // Sync behaviour
    // ~~~~~~~~~~~~~~~~~~~~

    // data_en is one register behind read_en, so run must already be up
    a_de_needs_run: assert property (@(posedge clk) disable iff (!rstn)
        $rose(sync.data_en) |-> $past(timing_run))
        else $error("data_en rose while the display timing was stopped");

    a_hsync_blank: assert property (@(posedge clk) disable iff (!rstn)
        !(sync.hsync && sync.data_en))
        else $error("hsync and data_en were high together");

    // ~~~~~~~~~~~~~~~~~~~~
    // FIFO health
    // ~~~~~~~~~~~~~~~~~~~~

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        !overflow)
        else $error("line FIFO overflow flag set");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn)
        !underflow)
        else $error("line FIFO underflow flag set");

endmodule : video_assert

bind video_top video_assert u_assert (
    .clk       (clk),
    .rstn      (rstn),
    .timing_run(timing_run),
    .sync      (sync),
    .overflow  (overflow),
    .underflow (underflow)
);

//--- tests/tb_video_top.sv
`timescale 1ns/100ps

module tb_video_top;

    import video_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;

    localparam int H_ACT      = 32;
    localparam int H_FP       = 4;
    localparam int H_SYNC     = 4;
    localparam int H_BP       = 8;
    localparam int V_ACT      = 6;
    localparam int V_FP       = 1;
    localparam int V_SYNC     = 1;
    localparam int V_BP       = 2;
    localparam int LOCK_LINES = 6;
    localparam int LOCK_LEAD  = 4;
    localparam int FIFO_DEPTH = 16;

    localparam int H_TOTAL      = H_ACT + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_ACT + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int START_DELAY  = (H_TOTAL - H_ACT) + (V_TOTAL - V_ACT) * H_TOTAL + LOCK_LEAD;
    localparam int CHECK_FRAMES = 3;

    // Lock frame, start delay, the checked frames and one frame of slack
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (CHECK_FRAMES + 2) * FRAME_CYCLES;

    logic        clk;
    logic        rstn;
    cam_stream_t cam;
    video_sync_t sync;
    coord_t      x;
    coord_t      y;
    pixel_t      pix;
    logic        overflow;
    logic        underflow;

    pixel_t pix_model[$];      // Pixels the display must show in arrival order
    int     cyc = 0;           // Clock count since reset release
    int     rise_cycle = 0;    // Cycle of the first expected data_en
    bit     rise_known;
    bit     checks_done;

    video_top #(
        .H_ACT     (H_ACT),
        .H_FP      (H_FP),
        .H_SYNC    (H_SYNC),
        .H_BP      (H_BP),
        .V_ACT     (V_ACT),
        .V_FP      (V_FP),
        .V_SYNC    (V_SYNC),
        .V_BP      (V_BP),
        .LOCK_LINES(LOCK_LINES),
        .LOCK_LEAD (LOCK_LEAD),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_dut (
        .clk      (clk),
        .rstn     (rstn),
        .cam      (cam),
        .sync     (sync),
        .x        (x),
        .y        (y),
        .pix      (pix),
        .overflow (overflow),
        .underflow(underflow)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("error: %s is 0x%0h, expected 0x%0h at cycle %0d",
                                     name, actual, expected, cyc));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("timeout: the display did not finish its checked frames in time");
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Camera model
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin : camera
        int          cam_h;
        int          cam_v;
        int          lines_done;
        logic [31:0] rnd;
        cam_h      = 0;
        cam_v      = 0;
        lines_done = 0;
        rnd        = 32'ha164_dfc8;
        @(posedge rstn);
        forever begin
            @(posedge clk);
            cyc = cyc + 1;
            if ((cam_h < H_ACT) && (cam_v < V_ACT)) begin
                rnd = next_random(rnd);
                cam.href <= 1'b1;
                cam.data <= rnd[15:0];
                if (lines_done >= LOCK_LINES) begin
                    pix_model.push_back(rnd[15:0]);   // Frames after the lock frame
                end
            end else begin
                cam.href <= 1'b0;
                if ((cam_h == H_ACT) && (cam_v < V_ACT)) begin
                    lines_done = lines_done + 1;
                    if (lines_done == LOCK_LINES) begin
                        // The DUT samples this low href on the next clock
                        rise_cycle = cyc + 1 + START_DELAY + 1;
                        rise_known = 1'b1;
                    end
                end
            end
            if (cam_h == H_TOTAL - 1) begin
                cam_h = 0;
                cam_v = (cam_v == V_TOTAL - 1) ? 0 : cam_v + 1;
            end else begin
                cam_h = cam_h + 1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Display checker
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin : monitor
        int     pos;
        int     col;
        int     row;
        bit     exp_de;
        bit     exp_hs;
        bit     exp_vs;
        pixel_t exp_pix;
        while (!checks_done) begin
            @(negedge clk);
            if (rstn) begin
                check_value("overflow", 32'(overflow), 32'd0);
                check_value("underflow", 32'(underflow), 32'd0);
                if (!rise_known || (cyc < rise_cycle)) begin
                    check_value("sync", 32'(sync), 32'd0);   // Still waiting for lock
                end else begin
                    pos    = cyc - rise_cycle;
                    col    = pos % H_TOTAL;
                    row    = (pos / H_TOTAL) % V_TOTAL;
                    exp_de = (col < H_ACT) && (row < V_ACT);
                    exp_hs = (col >= H_ACT + H_FP) && (col < H_ACT + H_FP + H_SYNC);
                    exp_vs = (row >= V_ACT + V_FP) && (row < V_ACT + V_FP + V_SYNC);
                    check_value("data_en", 32'(sync.data_en), 32'(exp_de));
                    check_value("hsync", 32'(sync.hsync), 32'(exp_hs));
                    check_value("vsync", 32'(sync.vsync), 32'(exp_vs));
                    if (exp_de) begin
                        check_value("x", 32'(x), 32'(col));
                        check_value("y", 32'(y), 32'(row));
                        if (pix_model.size() == 0) begin
                            report_failure("the display showed a pixel the camera never sent");
                        end
                        exp_pix = pix_model.pop_front();
                        check_value("pix", 32'(pix), 32'(exp_pix));
                    end
                    if (pos == CHECK_FRAMES * FRAME_CYCLES - 1) begin
                        checks_done = 1'b1;
                    end
                end
            end
        end
    end

    initial begin : main
        rstn = 1'b0;
        cam  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        wait (checks_done);
        @(negedge clk);
        check_value("overflow", 32'(overflow), 32'd0);
        check_value("underflow", 32'(underflow), 32'd0);
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_video_top

//--- sources.f
logic/video_pkg.sv
logic/display_lock.sv
logic/video_timing.sv
logic/line_fifo.sv
logic/video_top.sv
tests/video_assert.sv
tests/tb_video_top.sv

//--- run.sh
#!/bin/sh
# Build and run the video path simulation with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_video_top -f sources.f

# The log decides the result, so a stopped run must not end the script here
./obj_dir/Vtb_video_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation FAILED: run ended without a result"
    exit 1
fi
echo "Simulation PASSED"
